//--- verilog/i2s_rx_pkg.sv
`default_nettype none

package i2s_rx_pkg;

	////////////////////////////////////////
	// Audio format
	////////////////////////////////////////

	// Fixed 16-bit slots, 32 sck per frame
	localparam int SAMPLE_BITS = 16;
	// Flops in each serial input synchronizer
	localparam int SYNC_STAGES = 2;

	typedef logic [SAMPLE_BITS-1:0] sample_t;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	typedef logic [1:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [7:0] count_t;

	// Bit 0 is the enable
	localparam reg_addr_t ADDR_CTRL     = 2'd0;
	// Completed pairs, wraps
	localparam reg_addr_t ADDR_FRAMES   = 2'd1;
	// Dropped pairs, saturating, cleared by any write
	localparam reg_addr_t ADDR_OVERRUNS = 2'd2;
	// Constant block identifier
	localparam reg_addr_t ADDR_ID       = 2'd3;
	localparam reg_data_t ID_VALUE      = 8'h25;

	////////////////////////////////////////
	// State machines
	////////////////////////////////////////

	typedef enum logic [1:0] {RX_IDLE, RX_ARMED, RX_LEFT, RX_RIGHT} rx_state_t;
	typedef enum logic [1:0] {HS_EMPTY, HS_REQ, HS_WAIT_DROP} hs_state_t;

endpackage

`default_nettype wire

//--- verilog/i2s_rx_regs.sv
`default_nettype none

module i2s_rx_regs
	import i2s_rx_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_req,
	input  logic      cfg_write,
	input  reg_addr_t cfg_addr,
	input  reg_data_t cfg_wdata,
	output reg_data_t cfg_rdata,
	output logic      cfg_ack,
	input  logic      frame_done,
	input  logic      overrun,
	output logic      enable
);

	// One-clock strobe per request, ack follows on the next edge
	logic      access;
	count_t    frame_count;
	count_t    overrun_count;
	reg_data_t read_data;

	assign access = cfg_req && !cfg_ack;

	////////////////////////////////////////
	// Handshake, control and counters
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cfg_ack       <= 1'b0;
			enable        <= 1'b0;
			frame_count   <= '0;
			overrun_count <= '0;
		end
		else
		begin
			// Ack rises after the access, falls once req is gone
			if (access)
				cfg_ack <= 1'b1;
			else if (!cfg_req)
				cfg_ack <= 1'b0;
			if (access && cfg_write && cfg_addr == ADDR_CTRL)
				enable <= cfg_wdata[0];
			// Frame counter simply wraps at 256
			if (frame_done)
				frame_count <= frame_count + 1'b1;
			// Write clears, otherwise count up and stick at 255
			if (access && cfg_write && cfg_addr == ADDR_OVERRUNS)
				overrun_count <= '0;
			else if (overrun && overrun_count != '1)
				overrun_count <= overrun_count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	always_comb
	begin
		case (cfg_addr)
			ADDR_CTRL:     read_data = {7'd0, enable};
			ADDR_FRAMES:   read_data = frame_count;
			ADDR_OVERRUNS: read_data = overrun_count;
			default:       read_data = ID_VALUE;
		endcase
	end

	// Read data holds until the next read access
	always_ff @(posedge clk)
	begin
		if (access && !cfg_write)
			cfg_rdata <= read_data;
	end

endmodule

`default_nettype wire

//--- verilog/i2s_rx_deserializer.sv
`default_nettype none

module i2s_rx_deserializer
	import i2s_rx_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    sck,
	input  logic    ws,
	input  logic    sd,
	input  logic    enable,
	output logic    pair_valid,
	output logic    frame_done,
	output sample_t pair_left,
	output sample_t pair_right
);

	// sck synchronizer and edge detect
	logic [SYNC_STAGES-1:0] sck_sync;
	logic                   sck_prev;
	logic                   sck_rise;
	// ws and sd delayed to line up with sck_rise
	logic [SYNC_STAGES:0]   ws_pipe;
	logic [SYNC_STAGES:0]   sd_pipe;
	logic                   ws_now;
	logic                   sd_now;
	// ws as sampled at the previous sck rising edge
	logic                   ws_prev;
	logic                   ws_change;
	logic                   ws_fall;
	rx_state_t              state;
	sample_t                shift;
	sample_t                word_next;

	////////////////////////////////////////
	// Input synchronizers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sck_sync <= '0;
			sck_prev <= 1'b0;
			sck_rise <= 1'b0;
			ws_pipe  <= '0;
			sd_pipe  <= '0;
		end
		else
		begin
			sck_sync <= {sck_sync[SYNC_STAGES-2:0], sck};
			sck_prev <= sck_sync[SYNC_STAGES-1];
			// Registered strobe, 3 clocks after the pin edge
			sck_rise <= sck_sync[SYNC_STAGES-1] & ~sck_prev;
			// One extra stage matches the edge register
			ws_pipe  <= {ws_pipe[SYNC_STAGES-1:0], ws};
			sd_pipe  <= {sd_pipe[SYNC_STAGES-1:0], sd};
		end
	end

	assign ws_now = ws_pipe[SYNC_STAGES];
	assign sd_now = sd_pipe[SYNC_STAGES];

	// Track ws at every bit, whatever the state
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			ws_prev <= 1'b0;
		else if (sck_rise)
			ws_prev <= ws_now;
	end

	// A ws change marks the LSB of the word that is ending
	assign ws_change = sck_rise && (ws_now != ws_prev);
	assign ws_fall   = ws_change && !ws_now;

	////////////////////////////////////////
	// Frame tracking FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state      <= RX_IDLE;
			pair_valid <= 1'b0;
		end
		else
		begin
			pair_valid <= 1'b0;
			// Dropping enable aborts any frame in progress
			if (!enable)
				state <= RX_IDLE;
			else
			begin
				case (state)
					RX_IDLE:
						state <= RX_ARMED;
					// Sync on ws falling, the bit there belongs to an unseen word
					RX_ARMED:
						if (ws_fall)
							state <= RX_LEFT;
					RX_LEFT:
						if (ws_change)
							state <= RX_RIGHT;
					// Right LSB completes the pair
					RX_RIGHT:
						if (ws_change)
						begin
							state      <= RX_LEFT;
							pair_valid <= 1'b1;
						end
					default:
						state <= RX_IDLE;
				endcase
			end
		end
	end

	assign frame_done = pair_valid;

	////////////////////////////////////////
	// Shift register and word latches
	////////////////////////////////////////

	// MSB first, the newest bit enters at the bottom
	assign word_next = {shift[SAMPLE_BITS-2:0], sd_now};

	always_ff @(posedge clk)
	begin
		if (sck_rise)
		begin
			shift <= word_next;
			if (enable && ws_change && state == RX_LEFT)
				pair_left <= word_next;
			if (enable && ws_change && state == RX_RIGHT)
				pair_right <= word_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2s_rx_handoff.sv
`default_nettype none

module i2s_rx_handoff
	import i2s_rx_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    pair_valid,
	input  sample_t pair_left,
	input  sample_t pair_right,
	output logic    sample_req,
	output sample_t sample_left,
	output sample_t sample_right,
	input  logic    sample_ack,
	output logic    overrun
);

	hs_state_t state;
	// Only an empty holding stage accepts a new pair
	logic      capture;

	assign capture = pair_valid && state == HS_EMPTY;

	////////////////////////////////////////
	// Four-phase handshake FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state   <= HS_EMPTY;
			overrun <= 1'b0;
		end
		else
		begin
			// Pair arriving while one is held gets dropped
			overrun <= pair_valid && state != HS_EMPTY;
			case (state)
				HS_EMPTY:
					if (pair_valid)
						state <= HS_REQ;
				// Request stays up until the consumer acks
				HS_REQ:
					if (sample_ack)
						state <= HS_WAIT_DROP;
				// Ack must go low before the next request
				HS_WAIT_DROP:
					if (!sample_ack)
						state <= HS_EMPTY;
				default:
					state <= HS_EMPTY;
			endcase
		end
	end

	assign sample_req = (state == HS_REQ);

	// Held pair, never overwritten while requested
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			sample_left  <= pair_left;
			sample_right <= pair_right;
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2s_rx_top.sv
`default_nettype none

module i2s_rx_top
	import i2s_rx_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// Serial audio, asynchronous to clk
	input  logic      sck,
	input  logic      ws,
	input  logic      sd,
	// Configuration port
	input  logic      cfg_req,
	input  logic      cfg_write,
	input  reg_addr_t cfg_addr,
	input  reg_data_t cfg_wdata,
	output reg_data_t cfg_rdata,
	output logic      cfg_ack,
	// Sample port
	output logic      sample_req,
	output sample_t   sample_left,
	output sample_t   sample_right,
	input  logic      sample_ack
);

	logic    enable;
	logic    pair_valid;
	logic    frame_done;
	logic    overrun;
	sample_t pair_left;
	sample_t pair_right;

	i2s_rx_regs i2s_rx_regs_inst (
		.clk(clk), .rst(rst),
		.cfg_req(cfg_req), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .cfg_ack(cfg_ack),
		.frame_done(frame_done), .overrun(overrun), .enable(enable)
	);

	i2s_rx_deserializer i2s_rx_deserializer_inst (
		.clk(clk), .rst(rst), .sck(sck), .ws(ws), .sd(sd), .enable(enable),
		.pair_valid(pair_valid), .frame_done(frame_done),
		.pair_left(pair_left), .pair_right(pair_right)
	);

	i2s_rx_handoff i2s_rx_handoff_inst (
		.clk(clk), .rst(rst), .pair_valid(pair_valid),
		.pair_left(pair_left), .pair_right(pair_right),
		.sample_req(sample_req), .sample_left(sample_left),
		.sample_right(sample_right), .sample_ack(sample_ack), .overrun(overrun)
	);

endmodule

`default_nettype wire

//--- bench/tb_i2s_rx_assert.sv
`default_nettype none

module tb_i2s_rx_assert
	import i2s_rx_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    cfg_req,
	input logic    cfg_ack,
	input logic    sample_req,
	input logic    sample_ack,
	input sample_t sample_left,
	input sample_t sample_right,
	input logic    enable,
	input logic    pair_valid,
	input logic    overrun
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////
	// Sample port handshake
	////////////////////////////////////////

	// Request holds until the consumer acks
	req_held: assert property (@(posedge clk) disable iff (!rst)
		sample_req && !sample_ack |=> sample_req)
		else $error("sample_req dropped before sample_ack");

	// Held pair does not move while requested
	data_stable: assert property (@(posedge clk) disable iff (!rst)
		sample_req |=> !sample_req || ($stable(sample_left) && $stable(sample_right)))
		else $error("Sample data changed while sample_req was high");

	////////////////////////////////////////
	// Config port and enable
	////////////////////////////////////////

	// Ack only answers a pending request
	ack_on_req: assert property (@(posedge clk) disable iff (!rst)
		$rose(cfg_ack) |-> $past(cfg_req))
		else $error("cfg_ack rose without cfg_req");

	// Disabled block stays silent
	quiet_when_off: assert property (@(posedge clk) disable iff (!rst)
		!enable |-> !pair_valid && !overrun)
		else $error("pair_valid or overrun seen while disabled");

endmodule

`default_nettype wire

//--- bench/tb_i2s_rx.sv
`default_nettype none

module tb_i2s_rx
	import i2s_rx_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS        = 8;
	// Clocks per sck half period
	localparam int SCK_HALF    = 8;
	// Longer than one frame but shorter than two
	localparam int HOLD_CLOCKS = 600;
	localparam longint WATCHDOG_NS = (ROWS + 4) * 32 * 16 * 4 * 2;

	// Each row is {hold ack, left, right}
	localparam logic [32:0] TABLE [ROWS] = '{
		{1'b0, 16'h1234, 16'habcd},
		{1'b0, 16'h8001, 16'h7ffe},
		{1'b1, 16'hffff, 16'h0000},
		{1'b0, 16'h5a5a, 16'ha5a5},
		{1'b0, 16'h0f0f, 16'hf0f0},
		{1'b1, 16'h1357, 16'h2468},
		{1'b0, 16'h9bdf, 16'hace0},
		{1'b0, 16'hc3c3, 16'h3c3c}
	};

	logic      clk;
	logic      rst;
	logic      sck;
	logic      ws;
	logic      sd;
	logic      cfg_req;
	logic      cfg_write;
	reg_addr_t cfg_addr;
	reg_data_t cfg_wdata;
	reg_data_t cfg_rdata;
	logic      cfg_ack;
	logic      sample_req;
	sample_t   sample_left;
	sample_t   sample_right;
	logic      sample_ack;

	int          value_errors = 0;
	int          other_errors = 0;
	logic [31:0] rng          = 32'h07bc1c72;
	// Right LSB still owed to the line at the next frame start
	logic        last_lsb     = 1'b0;
	logic        prev_held;
	count_t      exp_frames   = '0;
	count_t      exp_overruns = '0;
	logic [32:0] exp_q [$];

	i2s_rx_top i2s_rx_top_inst (
		.clk(clk), .rst(rst), .sck(sck), .ws(ws), .sd(sd),
		.cfg_req(cfg_req), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .cfg_ack(cfg_ack),
		.sample_req(sample_req), .sample_left(sample_left),
		.sample_right(sample_right), .sample_ack(sample_ack)
	);

	bind i2s_rx_top tb_i2s_rx_assert i2s_rx_top_assert_inst (
		.clk(clk), .rst(rst), .cfg_req(cfg_req), .cfg_ack(cfg_ack),
		.sample_req(sample_req), .sample_ack(sample_ack),
		.sample_left(sample_left), .sample_right(sample_right),
		.enable(enable), .pair_valid(pair_valid), .overrun(overrun)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Drive and sample 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// Standard I2S, ws leads the MSB by one sck
	task automatic send_frame(input sample_t left, input sample_t right);
		logic [2*SAMPLE_BITS-1:0] word;
		word = {left, right};
		for (int i = 0; i < 2 * SAMPLE_BITS; i++)
		begin
			// Changes on the sck falling edge
			sck = 1'b0;
			ws  = (i >= SAMPLE_BITS);
			if (i == 0)
				sd = last_lsb;
			else
			begin
				sd   = word[2*SAMPLE_BITS-1];
				word = word << 1;
			end
			repeat (SCK_HALF) tick();
			sck = 1'b1;
			repeat (SCK_HALF) tick();
		end
		last_lsb = word[2*SAMPLE_BITS-1];
	endtask

	// Table rows plus a trailing frame that closes the last right word
	task automatic send_rows(input int first, input int last);
		for (int r = first; r <= last; r++)
			send_frame(TABLE[r][31:16], TABLE[r][15:0]);
		send_frame(16'h0000, 16'h0000);
	endtask

	task automatic cfg_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
			output reg_data_t rdata);
		cfg_write = wr;
		cfg_addr  = addr;
		cfg_wdata = wdata;
		cfg_req   = 1'b1;
		tick();
		while (!cfg_ack)
			tick();
		rdata   = cfg_rdata;
		cfg_req = 1'b0;
		while (cfg_ack)
			tick();
	endtask

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
		reg_data_t unused;
		cfg_access(1'b1, addr, data, unused);
	endtask

	task automatic reg_check(input reg_addr_t addr, input reg_data_t exp, input string name);
		reg_data_t rdata;
		cfg_access(1'b0, addr, 8'h00, rdata);
		assert (rdata == exp)
		else
		begin
			$display("Fail %s: got %h, expected %h", name, rdata, exp);
			value_errors++;
		end
	endtask

	// All expected pairs taken and the handshake back at rest
	task automatic wait_idle();
		tick();
		while (exp_q.size() != 0 || sample_req || sample_ack)
			tick();
	endtask

	////////////////////////////////////////
	// Consumer
	////////////////////////////////////////

	initial
	begin
		logic [32:0] entry;
		int          delay;
		logic        expected;
		forever
		begin
			tick();
			if (sample_req)
			begin
				expected = (exp_q.size() != 0);
				assert (expected)
				else
				begin
					$display("A sample pair was delivered when none was expected");
					other_errors++;
				end
				delay = 0;
				if (expected)
				begin
					entry = exp_q.pop_front();
					rng   = xorshift32(rng);
					// Held rows keep ack off across the next frame
					delay = entry[32] ? HOLD_CLOCKS : int'(rng[2:0]);
				end
				repeat (delay) tick();
				// Pair is taken at ack time, after any dropped frame
				if (expected)
				begin
					assert (sample_left == entry[31:16])
					else
					begin
						$display("Fail sample_left: got %h, expected %h",
							sample_left, entry[31:16]);
						value_errors++;
					end
					assert (sample_right == entry[15:0])
					else
					begin
						$display("Fail sample_right: got %h, expected %h",
							sample_right, entry[15:0]);
						value_errors++;
					end
				end
				sample_ack = 1'b1;
				while (sample_req)
					tick();
				sample_ack = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		rst        = 1'b0;
		sck        = 1'b1;
		ws         = 1'b1;
		sd         = 1'b0;
		cfg_req    = 1'b0;
		cfg_write  = 1'b0;
		cfg_addr   = ADDR_CTRL;
		cfg_wdata  = 8'h00;
		sample_ack = 1'b0;
		repeat (16) tick();
		rst = 1'b1;

		// Register map after reset
		reg_check(ADDR_CTRL, 8'h00, "ctrl");
		reg_check(ADDR_FRAMES, 8'h00, "frames");
		reg_check(ADDR_OVERRUNS, 8'h00, "overruns");
		reg_check(ADDR_ID, 8'h25, "id");
		reg_write(ADDR_CTRL, 8'h01);
		reg_check(ADDR_CTRL, 8'h01, "ctrl");
		reg_write(ADDR_CTRL, 8'h00);
		reg_check(ADDR_CTRL, 8'h00, "ctrl");

		// Disabled block ignores the line
		send_rows(0, 0);
		wait_idle();
		reg_check(ADDR_FRAMES, 8'h00, "frames");

		// Row 0 is in flight at enable, a held pair drops the next one
		prev_held = 1'b0;
		for (int r = 1; r < ROWS; r++)
		begin
			exp_frames++;
			if (prev_held)
			begin
				exp_overruns++;
				prev_held = 1'b0;
			end
			else
			begin
				exp_q.push_back(TABLE[r]);
				prev_held = TABLE[r][32];
			end
		end
		fork
			send_rows(0, ROWS - 1);
			begin
				repeat (100) tick();
				reg_write(ADDR_CTRL, 8'h01);
			end
		join
		wait_idle();
		reg_check(ADDR_FRAMES, exp_frames, "frames");
		reg_check(ADDR_OVERRUNS, exp_overruns, "overruns");

		// Any write clears the overrun count
		reg_write(ADDR_OVERRUNS, 8'h5a);
		reg_check(ADDR_OVERRUNS, 8'h00, "overruns");
		reg_check(ADDR_FRAMES, exp_frames, "frames");

		// Re-arm, then toggle enable inside the right slot of row 0
		reg_write(ADDR_CTRL, 8'h00);
		reg_write(ADDR_CTRL, 8'h01);
		exp_q.push_back({1'b0, TABLE[1][31:0]});
		exp_q.push_back({1'b0, TABLE[2][31:0]});
		exp_frames = exp_frames + 8'd2;
		fork
			send_rows(0, 2);
			begin
				repeat (300) tick();
				reg_write(ADDR_CTRL, 8'h00);
				repeat (20) tick();
				reg_write(ADDR_CTRL, 8'h01);
			end
		join
		wait_idle();
		reg_check(ADDR_FRAMES, exp_frames, "frames");
		reg_check(ADDR_OVERRUNS, 8'h00, "overruns");

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Hang guard sized from the table length
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/i2s_rx_pkg.sv
verilog/i2s_rx_regs.sv
verilog/i2s_rx_deserializer.sv
verilog/i2s_rx_handoff.sv
verilog/i2s_rx_top.sv
bench/tb_i2s_rx_assert.sv
bench/tb_i2s_rx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2s_rx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
